// ==== src/z80_bank_config.svh ====
`ifndef Z80_BANK_CONFIG_SVH
`define Z80_BANK_CONFIG_SVH

// I/O port of bank register 0, registers follow at +1..+3
`define Z80B_PORT_BASE 8'hA0

// Number of bank registers, also the size of the port window
`define Z80B_BANK_COUNT 8'd4

// Bank contents after reset
// Slots 0..3 map onto the first 64 KB of ROM
`define Z80B_RESET_BANK0 8'h00
`define Z80B_RESET_BANK1 8'h01
`define Z80B_RESET_BANK2 8'h02
`define Z80B_RESET_BANK3 8'h03

// phi divider width, phi is the MSB (sysclk / 4)
`define Z80B_PHI_DIV_BITS 2

`endif

// ==== src/z80_bank_pkg.sv ====
`default_nettype none

package z80_bank_pkg;

    //////////////////////////////////////////////////
    // Bus cycle kinds
    //////////////////////////////////////////////////

    // Decoded from the Z80 strobes, one per registered sysclk cycle
    typedef enum logic [2:0] {
        CYC_IDLE  = 3'd0,   // No strobe pair active
        CYC_MEMRD = 3'd1,   // mreq + rd
        CYC_MEMWR = 3'd2,   // mreq + wr
        CYC_IORD  = 3'd3,   // iorq + rd
        CYC_IOWR  = 3'd4    // iorq + wr
    } cycle_kind_e;

    //////////////////////////////////////////////////
    // Shared bundles
    //////////////////////////////////////////////////

    // Registered bus state, 27 bits
    typedef struct packed {
        cycle_kind_e kind;
        logic [15:0] addr;
        logic [7:0]  wdata;  // Write data, valid in write cycles
    } bus_cycle_t;

    // Four bank registers, index is the slot
    // Bits 5..0 physical bank, bit 7 write protect
    typedef logic [3:0][7:0] bank_file_t;

    // Memory decode result, 8 bits
    typedef struct packed {
        logic [5:0] bank;    // Physical bank of the addressed slot
        logic       ram_sel; // 512 KB RAM
        logic       rom_sel; // 256 KB flash
    } mem_sel_t;

endpackage

`default_nettype wire

// ==== src/bus_front.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "z80_bank_config.svh"

module bus_front (
    input  wire logic                     sysclk,
    input  wire logic                     reset,
    input  wire logic [15:0]              bus_a,
    input  wire logic [7:0]               data_in,
    input  wire logic                     bus_rd_n,
    input  wire logic                     bus_wr_n,
    input  wire logic                     bus_mreq_n,
    input  wire logic                     bus_iorq_n,
    output logic                          phi,         // CPU clock
    output z80_bank_pkg::bus_cycle_t      cycle,       // Registered bus
    output logic                          io_wr_pulse  // First cycle of IOWR
);
    import z80_bank_pkg::*;

    localparam logic [`Z80B_PHI_DIV_BITS-1:0] phi_step = 1;

    logic [`Z80B_PHI_DIV_BITS-1:0] phi_div;
    cycle_kind_e                   kind_next;
    cycle_kind_e                   kind_r;
    cycle_kind_e                   kind_prev;   // Kind one cycle earlier
    logic [15:0]                   addr_r;
    logic [7:0]                    wdata_r;

    //////////////////////////////////////////////////
    // phi generation
    //////////////////////////////////////////////////
    always_ff @(posedge sysclk) begin
        if (reset)
            phi_div <= '0;
        else
            phi_div <= phi_div + phi_step;  // Free running
    end

    assign phi = phi_div[`Z80B_PHI_DIV_BITS-1];  // MSB, sysclk / 4

    //////////////////////////////////////////////////
    // Cycle classification
    //////////////////////////////////////////////////
    always_comb begin
        kind_next = CYC_IDLE;  // Int ack, refresh, gaps
        if (!bus_mreq_n && !bus_rd_n)
            kind_next = CYC_MEMRD;
        else if (!bus_mreq_n && !bus_wr_n)
            kind_next = CYC_MEMWR;
        else if (!bus_iorq_n && !bus_rd_n)
            kind_next = CYC_IORD;
        else if (!bus_iorq_n && !bus_wr_n)
            kind_next = CYC_IOWR;
    end

    // Kind history, cleared so no pulse comes out of reset
    always_ff @(posedge sysclk) begin
        if (reset) begin
            kind_r    <= CYC_IDLE;
            kind_prev <= CYC_IDLE;
        end else begin
            kind_r    <= kind_next;
            kind_prev <= kind_r;
        end
    end

    // Address and data, payload only
    always_ff @(posedge sysclk) begin
        addr_r  <= bus_a;
        wdata_r <= data_in;
    end

    assign cycle = '{kind: kind_r, addr: addr_r, wdata: wdata_r};

    // Rising edge of IOWR, one pulse per held strobe
    assign io_wr_pulse = (kind_r == CYC_IOWR) && (kind_prev != CYC_IOWR);

endmodule

`default_nettype wire

// ==== src/bank_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "z80_bank_config.svh"

module bank_regs (
    input  wire logic                     sysclk,
    input  wire logic                     reset,
    input  wire z80_bank_pkg::bus_cycle_t cycle,
    input  wire logic                     io_wr_pulse,
    output z80_bank_pkg::bank_file_t      banks
);
    import z80_bank_pkg::*;

    logic [7:0] port_off;   // Offset from port base, wraps below base
    logic       port_hit;   // Inside A0h..A3h
    logic [1:0] slot;

    //////////////////////////////////////////////////
    // Port window decode
    //////////////////////////////////////////////////

    // Only the low address byte counts, Z80 puts A on the high byte
    assign port_off = cycle.addr[7:0] - `Z80B_PORT_BASE;
    assign port_hit = port_off < `Z80B_BANK_COUNT;
    assign slot     = port_off[1:0];

    //////////////////////////////////////////////////
    // Bank register file
    //////////////////////////////////////////////////
    always_ff @(posedge sysclk) begin
        if (reset) begin
            banks[0] <= `Z80B_RESET_BANK0;  // Boot from ROM bank 0
            banks[1] <= `Z80B_RESET_BANK1;
            banks[2] <= `Z80B_RESET_BANK2;
            banks[3] <= `Z80B_RESET_BANK3;
        end else if (io_wr_pulse && port_hit) begin
            banks[slot] <= cycle.wdata;     // Whole byte, incl. protect bit
        end
    end

    // Writes outside the window fall through, other devices own them

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Pulse from bus_front must line up with its own cycle kind
    a_pulse_is_iowr : assert property (
        @(posedge sysclk) disable iff (reset)
        io_wr_pulse |-> (cycle.kind == CYC_IOWR)
    ) else $error("io_wr_pulse outside an I/O write cycle");

endmodule

`default_nettype wire

// ==== src/mem_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_decode (
    input  wire logic                     sysclk,  // Assertions only
    input  wire logic                     reset,   // Assertions only
    input  wire z80_bank_pkg::bus_cycle_t cycle,
    input  wire z80_bank_pkg::bank_file_t banks,
    output z80_bank_pkg::mem_sel_t        sel
);
    import z80_bank_pkg::*;

    logic [7:0] bank_entry;  // Register of the addressed slot
    logic       is_mem;
    logic       is_write;
    logic       ram_region;  // Banks 32..63
    logic       rom_region;  // Banks 0..15
    logic       blocked;

    //////////////////////////////////////////////////
    // Slot to bank
    //////////////////////////////////////////////////
    assign bank_entry = banks[cycle.addr[15:14]];  // 16 KB slots
    assign sel.bank   = bank_entry[5:0];           // Shown in every cycle

    //////////////////////////////////////////////////
    // Region and protection
    //////////////////////////////////////////////////
    assign is_write   = cycle.kind == CYC_MEMWR;
    assign is_mem     = (cycle.kind == CYC_MEMRD) || is_write;
    assign ram_region = bank_entry[5];
    assign rom_region = bank_entry[5:4] == 2'b00;
    // Banks 16..31 land in neither region, no chip there

    // Protect bit, or any write aimed at flash
    assign blocked = is_write && (bank_entry[7] || rom_region);

    assign sel.ram_sel = is_mem && ram_region && !blocked;
    assign sel.rom_sel = is_mem && rom_region && !blocked;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    a_one_chip : assert property (
        @(posedge sysclk) disable iff (reset)
        !(sel.ram_sel && sel.rom_sel)
    ) else $error("RAM and ROM selected together");

    a_idle_quiet : assert property (
        @(posedge sysclk) disable iff (reset)
        (cycle.kind == CYC_IDLE) |-> !(sel.ram_sel || sel.rom_sel)
    ) else $error("Chip selected in an idle cycle");

endmodule

`default_nettype wire

// ==== src/bus_respond.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "z80_bank_config.svh"

module bus_respond (
    input  wire logic                     sysclk,
    input  wire logic                     reset,
    input  wire z80_bank_pkg::bus_cycle_t cycle,
    input  wire z80_bank_pkg::bank_file_t banks,
    output logic [7:0]                    data_out,
    output logic                          data_oe    // Drive the Z80 data bus
);
    import z80_bank_pkg::*;

    logic [7:0] port_off;
    logic       read_hit;   // IORD of A0h..A3h

    //////////////////////////////////////////////////
    // Read decode
    //////////////////////////////////////////////////
    assign port_off = cycle.addr[7:0] - `Z80B_PORT_BASE;
    assign read_hit = (cycle.kind == CYC_IORD) && (port_off < `Z80B_BANK_COUNT);

    //////////////////////////////////////////////////
    // Read data register
    //////////////////////////////////////////////////
    always_ff @(posedge sysclk) begin
        if (reset) begin
            data_out <= 8'h00;
            data_oe  <= 1'b0;
        end else if (read_hit) begin
            data_out <= banks[port_off[1:0]];  // Full byte incl. protect bit
            data_oe  <= 1'b1;
        end else begin
            data_out <= 8'h00;  // Quiet bus when not driving
            data_oe  <= 1'b0;
        end
    end

    // Other ports are answered by someone else, stay off the bus

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Drive drops one cycle after the read ends, no bus fight
    a_oe_follows_iord : assert property (
        @(posedge sysclk) disable iff (reset)
        (cycle.kind != CYC_IORD) |=> !data_oe
    ) else $error("data_oe high after a non-IORD cycle");

endmodule

`default_nettype wire

// ==== src/z80_bank_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module z80_bank_top (
    input  wire logic        sysclk,
    input  wire logic        reset,
    input  wire logic [15:0] bus_a,
    input  wire logic [7:0]  data_in,     // Z80 data bus, input half
    input  wire logic        bus_rd_n,
    input  wire logic        bus_wr_n,
    input  wire logic        bus_mreq_n,
    input  wire logic        bus_iorq_n,
    output logic             phi,
    output logic [7:0]       data_out,    // Z80 data bus, output half
    output logic             data_oe,
    output logic             ram_cs_n,    // 512 KB RAM
    output logic             rom_cs_n,    // 256 KB flash
    output logic [5:0]       bank_a       // Physical bank, upper memory address
);
    import z80_bank_pkg::*;

    bus_cycle_t cycle;
    logic       io_wr_pulse;
    bank_file_t banks;
    mem_sel_t   sel;

    // Pins in, registered bus out
    bus_front u_front (
        .sysclk      (sysclk),
        .reset       (reset),
        .bus_a       (bus_a),
        .data_in     (data_in),
        .bus_rd_n    (bus_rd_n),
        .bus_wr_n    (bus_wr_n),
        .bus_mreq_n  (bus_mreq_n),
        .bus_iorq_n  (bus_iorq_n),
        .phi         (phi),
        .cycle       (cycle),
        .io_wr_pulse (io_wr_pulse)
    );

    bank_regs u_regs (
        .sysclk      (sysclk),
        .reset       (reset),
        .cycle       (cycle),
        .io_wr_pulse (io_wr_pulse),
        .banks       (banks)
    );

    mem_decode u_decode (
        .sysclk (sysclk),
        .reset  (reset),
        .cycle  (cycle),
        .banks  (banks),
        .sel    (sel)
    );

    bus_respond u_respond (
        .sysclk   (sysclk),
        .reset    (reset),
        .cycle    (cycle),
        .banks    (banks),
        .data_out (data_out),
        .data_oe  (data_oe)
    );

    // Active-low chip selects
    assign ram_cs_n = !sel.ram_sel;
    assign rom_cs_n = !sel.rom_sel;
    assign bank_a   = sel.bank;

endmodule

`default_nettype wire

// ==== test/tb_z80_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "z80_bank_config.svh"

module tb_z80_bank;

    logic        sysclk;
    logic        reset;
    logic [15:0] bus_a;
    logic [7:0]  data_in;
    logic        bus_rd_n;
    logic        bus_wr_n;
    logic        bus_mreq_n;
    logic        bus_iorq_n;
    logic        phi;
    logic [7:0]  data_out;
    logic        data_oe;
    logic        ram_cs_n;
    logic        rom_cs_n;
    logic [5:0]  bank_a;

    logic [7:0]  model_banks [4];  // Expected bank registers
    logic [31:0] rng_state;
    int          err_count;
    int          timeout_count;
    int          check_count;

    z80_bank_top dut0 (
        .sysclk     (sysclk),
        .reset      (reset),
        .bus_a      (bus_a),
        .data_in    (data_in),
        .bus_rd_n   (bus_rd_n),
        .bus_wr_n   (bus_wr_n),
        .bus_mreq_n (bus_mreq_n),
        .bus_iorq_n (bus_iorq_n),
        .phi        (phi),
        .data_out   (data_out),
        .data_oe    (data_oe),
        .ram_cs_n   (ram_cs_n),
        .rom_cs_n   (rom_cs_n),
        .bank_a     (bank_a)
    );

    always #50 sysclk = ~sysclk;  // 100 ns period

    //////////////////////////////////////////////////
    // Bus helpers
    //////////////////////////////////////////////////

    // Step to 5 ns past the next rising edge
    task automatic tick();
        @(posedge sysclk);
        #5;
    endtask

    task automatic bus_idle();
        bus_rd_n   = 1'b1;
        bus_wr_n   = 1'b1;
        bus_mreq_n = 1'b1;
        bus_iorq_n = 1'b1;
    endtask

    // Classic LCG, top bits used by callers
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Expected {ram, rom} from a bank register, per the banking rules
    function automatic logic [1:0] expect_sel(input logic [7:0] entry, input logic write);
        logic [5:0] bank;
        logic       ram;
        logic       rom;
        bank = entry[5:0];
        ram  = (bank >= 6'd32);          // RAM banks 32..63
        rom  = (bank <= 6'd15);          // Flash banks 0..15
        if (write && (entry[7] || rom)) begin
            ram = 1'b0;                  // Protected, or flash
            rom = 1'b0;
        end
        return {ram, rom};
    endfunction

    task automatic io_write(input logic [7:0] port, input logic [7:0] value);
        logic [7:0] off;
        off        = port - `Z80B_PORT_BASE;
        bus_a      = {8'h00, port};
        data_in    = value;
        bus_iorq_n = 1'b0;
        bus_wr_n   = 1'b0;
        repeat (4) tick();               // Strobe held 4 cycles
        bus_idle();
        repeat (2) tick();               // Let the register settle
        if (off < 8'd4)
            model_banks[off[1:0]] = value;
    endtask

    task automatic io_read(input logic [7:0] port);
        logic [7:0] off;
        logic       seen;
        logic [7:0] got;
        int         i;
        off        = port - `Z80B_PORT_BASE;
        seen       = 1'b0;
        got        = 8'h00;
        bus_a      = {8'h00, port};
        bus_iorq_n = 1'b0;
        bus_rd_n   = 1'b0;
        for (i = 0; i < 8 && !seen; i++) begin
            tick();
            if (data_oe) begin
                seen = 1'b1;
                got  = data_out;
            end
        end
        bus_idle();
        for (i = 0; i < 8 && data_oe; i++)  // Drive must drop after release
            tick();
        if (data_oe) begin
            $display("Timeout: data_oe stayed high after reading port %h", port);
            timeout_count++;
        end
        check_count++;
        if (off < 8'd4) begin
            if (!seen) begin
                $display("Timeout: no data_oe for read of port %h", port);
                timeout_count++;
            end else if (got !== model_banks[off[1:0]]) begin
                $display("ERR %0t: port %h read %h, expected %h",
                         $time, port, got, model_banks[off[1:0]]);
                err_count++;
            end
        end else if (seen) begin
            $display("ERR %0t: data_oe raised for unmapped port %h", $time, port);
            err_count++;
        end
    endtask

    // Chip selects sampled 2 cycles into the strobe
    task automatic mem_access(input logic [15:0] addr, input logic write);
        logic [7:0] entry;
        logic [1:0] exp;
        entry      = model_banks[addr[15:14]];
        exp        = expect_sel(entry, write);
        bus_a      = addr;
        data_in    = 8'h5A;
        bus_mreq_n = 1'b0;
        bus_rd_n   = write;
        bus_wr_n   = !write;
        repeat (2) tick();
        check_count++;
        if (bank_a !== entry[5:0] || ram_cs_n !== !exp[1] || rom_cs_n !== !exp[0]) begin
            $display("ERR %0t: %s %h bank_a %0d ram_cs_n %b rom_cs_n %b, expected %0d %b %b",
                     $time, write ? "write" : "read", addr, bank_a, ram_cs_n, rom_cs_n,
                     entry[5:0], !exp[1], !exp[0]);
            err_count++;
        end
        bus_idle();
        tick();
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic check_after_reset();
        int s;
        check_count++;
        if (data_oe !== 1'b0 || ram_cs_n !== 1'b1 || rom_cs_n !== 1'b1) begin
            $display("ERR %0t: outputs active after reset", $time);
            err_count++;
        end
        for (s = 0; s < 4; s++)
            mem_access({s[1:0], 14'h0123}, 1'b0);  // Boot ROM banks 0..3
    endtask

    task automatic port_round_trip();
        int n;
        for (n = 0; n < 4; n++) begin
            io_write(`Z80B_PORT_BASE + {6'd0, n[1:0]}, 8'h30 + {6'd0, n[1:0]} + 8'h81);
            io_read(`Z80B_PORT_BASE + {6'd0, n[1:0]});
        end
        io_read(8'hA4);                  // Outside the window
        io_write(8'hA4, 8'h3F);          // Ignored by the DUT and the model
        for (n = 0; n < 4; n++)
            io_read(`Z80B_PORT_BASE + {6'd0, n[1:0]});
    endtask

    task automatic slot_mapping();
        io_write(8'hA0, 8'd40);          // RAM
        io_write(8'hA1, 8'd5);           // ROM
        io_write(8'hA2, 8'd20);          // Hole, no chip
        io_write(8'hA3, 8'h21);
        mem_access(16'h0010, 1'b0);
        mem_access(16'h7FFF, 1'b0);
        mem_access(16'h8800, 1'b0);
        mem_access(16'hC400, 1'b0);
    endtask

    task automatic write_protection();
        io_write(8'hA3, 8'hA1);          // RAM bank 33, protected
        mem_access(16'hC000, 1'b1);
        mem_access(16'hC000, 1'b0);      // Reads still go through
        io_write(8'hA3, 8'h21);
        mem_access(16'hC100, 1'b1);
        mem_access(16'h4000, 1'b1);      // Flash bank 5
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        int          k;
        rng_state = 32'd77;
        for (k = 0; k < 40; k++) begin
            r = next_random();
            if (r[30])
                io_write(8'hA0 + {5'd0, r[29:27]}, r[23:16]);  // A0h..A7h
            else
                mem_access(r[26:11], 1'b0);
        end
    endtask

    task automatic phi_period();
        logic last;
        int   rises;
        int   first_rise;
        int   second_rise;
        int   i;
        last        = phi;
        rises       = 0;
        first_rise  = 0;
        second_rise = 0;
        for (i = 0; i < 40 && rises < 2; i++) begin
            tick();
            if (phi && !last) begin
                rises++;
                if (rises == 1)
                    first_rise = i;
                else
                    second_rise = i;
            end
            last = phi;
        end
        check_count++;
        if (rises < 2) begin
            $display("Timeout: phi did not toggle within 40 sysclk cycles");
            timeout_count++;
        end else if (second_rise - first_rise != 4) begin
            $display("ERR %0t: phi period %0d cycles, expected 4", $time,
                     second_rise - first_rise);
            err_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        sysclk         = 1'b0;
        reset          = 1'b1;
        bus_a          = 16'h0000;
        data_in        = 8'h00;
        bus_idle();
        rng_state      = 32'd77;
        err_count      = 0;
        timeout_count  = 0;
        check_count    = 0;
        model_banks[0] = 8'h00;          // First 64 KB of ROM after reset
        model_banks[1] = 8'h01;
        model_banks[2] = 8'h02;
        model_banks[3] = 8'h03;
        repeat (16) @(posedge sysclk);
        #5;
        reset = 1'b0;
        tick();
        check_after_reset();
        port_round_trip();
        slot_mapping();
        write_protection();
        random_traffic();
        phi_period();
        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/z80_bank_pkg.sv
src/bus_front.sv
src/bank_regs.sv
src/mem_decode.sv
src/bus_respond.sv
src/z80_bank_top.sv
test/tb_z80_bank.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_z80_bank \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vtb_z80_bank 2>&1)"
echo "$out"
echo "$out" | grep -qx "ALL TESTS PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
